//--- common/dcache_consts.svh
// Data cache constants
// Sizes shared by the cache packages and RTL
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Data and address width
`define DCACHE_XLEN 32

// Cache organisation
`define DCACHE_SETS  16  // Number of sets
`define DCACHE_WAYS  2   // Set associativity
`define DCACHE_BURST 4   // Words per line, one INCR4 burst

// Addresses with this bit set bypass the cache
`define DCACHE_UNCACHED_BIT 31

`endif

//--- common/dcache_pkg.sv
// Data cache package
// Address fields, line storage, CPU request/response and controller states
`include "dcache_consts.svh"

package dcache_pkg;

  typedef logic [`DCACHE_XLEN-1:0]                 word_t;    // One data word
  typedef logic [`DCACHE_XLEN-1:0]                 addr_t;    // Byte address
  typedef logic [$clog2(`DCACHE_SETS)-1:0]         idx_t;     // Set index
  typedef logic [$clog2(`DCACHE_BURST)-1:0]        offs_t;    // Word in line
  typedef logic [`DCACHE_XLEN-$clog2(`DCACHE_SETS)-$clog2(`DCACHE_BURST)
                 -$clog2(`DCACHE_XLEN/8)-1:0]      tag_t;     // Line tag
  typedef logic [`DCACHE_BURST*`DCACHE_XLEN-1:0]   line_t;    // Whole line
  typedef logic [`DCACHE_WAYS-1:0]                 way_sel_t; // One-hot way

  // CPU side request, held stable until ack
  typedef struct packed {
    logic  req;
    addr_t adr;
    logic  we;
    word_t d;
  } mem_req_t;

  // CPU side response, ack is a single cycle
  typedef struct packed {
    logic  ack;
    logic  err;   // Only valid with ack
    word_t q;
  } mem_rsp_t;

  typedef enum logic [2:0] {IDLE, LOOKUP, FILL, RESPOND, WRITE, UNCACHED, FLUSH} ctrl_state_t;

endpackage

//--- common/biu_pkg.sv
// Bus interface package
// Strobe/ack bus request and response, burst types, sequencer commands
package biu_pkg;
  import dcache_pkg::*;

  typedef enum logic {SINGLE, INCR4} biu_type_t;

  // Bus request, fields steady while waiting for ack
  typedef struct packed {
    logic      stb;
    addr_t     adr;
    logic      we;
    word_t     d;
    biu_type_t btype;
  } biu_req_t;

  // One ack per beat, q on reads
  typedef struct packed {
    logic  ack;
    logic  err;
    word_t q;
  } biu_rsp_t;

  // Controller to sequencer
  typedef enum logic [1:0] {NOP, READ_LINE, READ_WORD, WRITE_WORD} biucmd_t;

endpackage

//--- dcache/dcache_memory.sv
// Data cache arrays
// Per-way tag, valid and data storage with registered lookup, hit compare,
// line fill into an LFSR-chosen way, word update and flash invalidate
`include "dcache_consts.svh"

module dcache_memory import dcache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  lookup_i,
  input  idx_t  idx_i,
  input  tag_t  tag_i,
  input  offs_t offs_i,
  input  logic  fill_i,
  input  line_t fill_line_i,
  input  logic  update_i,
  input  word_t update_d_i,
  input  logic  invalidate_i,
  output logic  hit_o,
  output line_t line_o
);

  logic [6:0] lfsr_q;                          // Random replacement
  way_sel_t   fill_way;
  way_sel_t   hit_way;
  way_sel_t   rd_valid_q;
  way_sel_t   valid_q   [`DCACHE_SETS];        // Valid mask per set
  tag_t       tag_arr   [`DCACHE_WAYS][`DCACHE_SETS];
  line_t      data_arr  [`DCACHE_WAYS][`DCACHE_SETS];
  tag_t       rd_tag_q  [`DCACHE_WAYS];
  line_t      rd_line_q [`DCACHE_WAYS];
  tag_t       lk_tag_q;                        // Tag being looked up

  //--------------------------------------------------------------------
  // Way selection
  //--------------------------------------------------------------------
  // Frozen during a fill so the chosen way stays put
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '0;
    end else if (!fill_i) begin
      lfsr_q <= {lfsr_q[5:0], lfsr_q[6] ~^ lfsr_q[5]};  // XNOR taps, zero is legal
    end
  end

  assign fill_way = way_sel_t'(1) << lfsr_q[$clog2(`DCACHE_WAYS)-1:0];

  //--------------------------------------------------------------------
  // Valid bits
  //--------------------------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < `DCACHE_SETS; s++) begin
        valid_q[s] <= '0;
      end
      rd_valid_q <= '0;
    end else begin
      if (invalidate_i) begin
        for (int s = 0; s < `DCACHE_SETS; s++) begin
          valid_q[s] <= '0;            // Whole cache in one cycle
        end
      end else if (fill_i) begin
        valid_q[idx_i] <= valid_q[idx_i] | fill_way;
      end
      if (lookup_i) begin
        rd_valid_q <= valid_q[idx_i];
      end
    end
  end

  //--------------------------------------------------------------------
  // Tag and data arrays
  //--------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      lk_tag_q <= tag_i;
      for (int w = 0; w < `DCACHE_WAYS; w++) begin
        rd_tag_q[w]  <= tag_arr[w][idx_i];
        rd_line_q[w] <= data_arr[w][idx_i];
      end
    end
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      if (fill_i && fill_way[w]) begin
        tag_arr[w][idx_i]  <= tag_i;
        data_arr[w][idx_i] <= fill_line_i;
      end else if (update_i && hit_way[w]) begin
        data_arr[w][idx_i][offs_i*`DCACHE_XLEN +: `DCACHE_XLEN] <= update_d_i;  // Hit way only
      end
    end
  end

  // Compare on the registered read
  always_comb begin
    line_o = '0;
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      hit_way[w] = rd_valid_q[w] && (rd_tag_q[w] == lk_tag_q);
      if (hit_way[w]) begin
        line_o = rd_line_q[w];
      end
    end
  end

  assign hit_o = |hit_way;

endmodule

//--- dcache/dcache_biu.sv
// Data cache bus sequencer
// Turns controller commands into single accesses or INCR4 line bursts
// and assembles the read beats into a line
`include "dcache_consts.svh"

module dcache_biu import dcache_pkg::*, biu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  biucmd_t  biucmd_i,
  input  addr_t    adr_i,
  input  word_t    d_i,
  output logic     busy_o,     // Access in progress
  output logic     done_o,     // Final beat acked
  output logic     err_o,
  output word_t    q_o,
  output line_t    line_o,     // Complete line during the done cycle
  output biu_req_t biu_req_o,
  input  biu_rsp_t biu_rsp_i
);

  localparam addr_t LINE_MASK = addr_t'(`DCACHE_BURST*`DCACHE_XLEN/8 - 1);
  localparam addr_t WORD_INC  = addr_t'(`DCACHE_XLEN/8);

  biu_req_t req_q;
  offs_t    beat_q;     // Burst beat counter
  line_t    line_q;     // Shift buffer, newest beat on top
  logic     beat_ack;
  logic     last_beat;

  assign beat_ack  = req_q.stb & biu_rsp_i.ack;
  assign last_beat = (req_q.btype == SINGLE) | biu_rsp_i.err      // Error ends it early
                   | (beat_q == offs_t'(`DCACHE_BURST-1));

  //--------------------------------------------------------------------
  // Access sequencing
  //--------------------------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= '0;
      beat_q <= '0;
    end else if (!req_q.stb) begin
      if (biucmd_i != NOP) begin
        req_q.stb <= 1'b1;
        req_q.we  <= (biucmd_i == WRITE_WORD);
        req_q.d   <= d_i;
        beat_q    <= '0;
        if (biucmd_i == READ_LINE) begin
          req_q.adr   <= adr_i & ~LINE_MASK;  // Burst from word 0
          req_q.btype <= INCR4;
        end else begin
          req_q.adr   <= adr_i;
          req_q.btype <= SINGLE;
        end
      end
    end else if (beat_ack) begin
      if (last_beat) begin
        req_q.stb <= 1'b0;
      end else begin
        beat_q    <= beat_q + 1'b1;
        req_q.adr <= req_q.adr + WORD_INC;    // Next beat address
      end
    end
  end

  // Read beats shift down, word 0 lands at the bottom
  always_ff @(posedge clk_i) begin
    if (beat_ack && !req_q.we) begin
      line_q <= line_o;
    end
  end

  assign line_o    = {biu_rsp_i.q, line_q[$bits(line_t)-1:`DCACHE_XLEN]};
  assign busy_o    = req_q.stb;
  assign done_o    = beat_ack & last_beat;
  assign err_o     = beat_ack & biu_rsp_i.err;
  assign q_o       = biu_rsp_i.q;
  assign biu_req_o = req_q;

endmodule

//--- dcache/dcache_ctrl.sv
// Data cache controller
// One request at a time through lookup, line fill, write-through or
// uncached access; holds a flush request until idle
`include "dcache_consts.svh"

module dcache_ctrl import dcache_pkg::*, biu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mem_req_t mem_req_i,
  output mem_rsp_t mem_rsp_o,
  input  logic     cache_flush_i,
  output logic     cache_flush_rdy_o,
  output logic     lookup_o,      // Start synchronous tag/data read
  output idx_t     idx_o,
  output tag_t     tag_o,
  output offs_t    offs_o,
  input  logic     hit_i,         // Valid the cycle after lookup
  input  line_t    line_i,
  output logic     fill_o,
  output line_t    fill_line_o,
  output logic     update_o,      // Write one word into the hit way
  output word_t    update_d_o,
  output logic     invalidate_o,
  output biucmd_t  biucmd_o,      // Held until done
  output addr_t    biu_adr_o,
  output word_t    biu_d_o,
  input  logic     biu_busy_i,
  input  logic     biu_done_i,
  input  logic     biu_err_i,
  input  word_t    biu_q_i,
  input  line_t    biu_line_i
);

  localparam int BYTE_W = $clog2(`DCACHE_XLEN/8);  // Byte offset bits

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  mem_rsp_t    rsp_q;
  mem_rsp_t    rsp_d;
  logic        flush_pend_q;
  logic        flush_rdy_q;
  logic        flush_rdy_d;
  logic        uncached;

  // Pick one word out of a line
  function automatic word_t line_word(line_t line, offs_t offs);
    return line[offs*`DCACHE_XLEN +: `DCACHE_XLEN];
  endfunction

  //--------------------------------------------------------------------
  // Address split
  //--------------------------------------------------------------------
  assign tag_o    = mem_req_i.adr[`DCACHE_XLEN-1 -: $bits(tag_t)];
  assign idx_o    = mem_req_i.adr[BYTE_W+$bits(offs_t) +: $bits(idx_t)];
  assign offs_o   = mem_req_i.adr[BYTE_W +: $bits(offs_t)];
  assign uncached = mem_req_i.adr[`DCACHE_UNCACHED_BIT];  // Bypass region

  // Request payload straight to arrays and bus
  assign fill_line_o = biu_line_i;
  assign update_d_o  = mem_req_i.d;
  assign biu_adr_o   = mem_req_i.adr;
  assign biu_d_o     = mem_req_i.d;

  //--------------------------------------------------------------------
  // Request FSM
  //--------------------------------------------------------------------
  always_comb begin
    state_d      = state_q;
    rsp_d        = rsp_q;
    rsp_d.ack    = 1'b0;   // Single cycle pulse
    rsp_d.err    = 1'b0;
    flush_rdy_d  = 1'b0;
    lookup_o     = 1'b0;
    fill_o       = 1'b0;
    update_o     = 1'b0;
    invalidate_o = 1'b0;
    biucmd_o     = NOP;

    unique case (state_q)
      IDLE: begin
        if (!biu_busy_i) begin
          if (flush_pend_q) begin
            state_d = FLUSH;       // Flush wins over a new request
          end else if (mem_req_i.req) begin
            if (uncached) begin
              state_d = UNCACHED;
            end else begin
              lookup_o = 1'b1;
              state_d  = LOOKUP;
            end
          end
        end
      end

      LOOKUP: begin
        if (mem_req_i.we) begin
          state_d = WRITE;         // Always goes to the bus
        end else if (hit_i) begin
          rsp_d.ack = 1'b1;
          rsp_d.q   = line_word(line_i, offs_o);
          state_d   = RESPOND;
        end else begin
          state_d = FILL;
        end
      end

      FILL: begin
        biucmd_o = READ_LINE;
        if (biu_done_i) begin
          fill_o    = ~biu_err_i;  // Failed line is never validated
          rsp_d.ack = 1'b1;
          rsp_d.err = biu_err_i;
          rsp_d.q   = line_word(biu_line_i, offs_o);
          state_d   = RESPOND;
        end
      end

      WRITE: begin
        biucmd_o = WRITE_WORD;
        if (biu_done_i) begin
          update_o  = hit_i & ~biu_err_i;  // No allocate on miss
          rsp_d.ack = 1'b1;
          rsp_d.err = biu_err_i;
          state_d   = RESPOND;
        end
      end

      UNCACHED: begin
        biucmd_o = mem_req_i.we ? WRITE_WORD : READ_WORD;
        if (biu_done_i) begin
          rsp_d.ack = 1'b1;
          rsp_d.err = biu_err_i;
          rsp_d.q   = biu_q_i;
          state_d   = RESPOND;
        end
      end

      RESPOND: state_d = IDLE;     // ack high; requester drops req

      FLUSH: begin
        invalidate_o = 1'b1;
        flush_rdy_d  = 1'b1;
        state_d      = IDLE;
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      rsp_q        <= '0;
      flush_pend_q <= 1'b0;
      flush_rdy_q  <= 1'b0;
    end else begin
      state_q      <= state_d;
      rsp_q        <= rsp_d;
      flush_pend_q <= cache_flush_i | (flush_pend_q & (state_q != FLUSH));  // Hold till served
      flush_rdy_q  <= flush_rdy_d;
    end
  end

  assign mem_rsp_o         = rsp_q;
  assign cache_flush_rdy_o = flush_rdy_q;

endmodule

//--- dcache/dcache_top.sv
// Data cache top level
// Write-through, 2-way set associative cache with a strobe/ack bus master
module dcache_top import dcache_pkg::*, biu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mem_req_t mem_req_i,          // CPU request
  output mem_rsp_t mem_rsp_o,          // CPU response
  input  logic     cache_flush_i,      // Invalidate whole cache
  output logic     cache_flush_rdy_o,  // Flush complete pulse
  output biu_req_t biu_req_o,
  input  biu_rsp_t biu_rsp_i
);

  // Controller <-> arrays
  logic    lookup;
  logic    hit;
  logic    fill;
  logic    update;
  logic    invalidate;
  idx_t    idx;
  tag_t    tag;
  offs_t   offs;
  line_t   cache_line;
  line_t   fill_line;
  word_t   update_d;

  // Controller <-> sequencer
  biucmd_t biucmd;
  addr_t   biu_adr;
  word_t   biu_d;
  word_t   biu_q;
  line_t   biu_line;
  logic    biu_busy;
  logic    biu_done;
  logic    biu_err;

  dcache_ctrl ctrl_inst (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .mem_req_i (mem_req_i), .mem_rsp_o (mem_rsp_o),
    .cache_flush_i (cache_flush_i), .cache_flush_rdy_o (cache_flush_rdy_o),
    .lookup_o (lookup), .idx_o (idx), .tag_o (tag), .offs_o (offs),
    .hit_i (hit), .line_i (cache_line),
    .fill_o (fill), .fill_line_o (fill_line),
    .update_o (update), .update_d_o (update_d),
    .invalidate_o (invalidate),
    .biucmd_o (biucmd), .biu_adr_o (biu_adr), .biu_d_o (biu_d),
    .biu_busy_i (biu_busy), .biu_done_i (biu_done), .biu_err_i (biu_err),
    .biu_q_i (biu_q), .biu_line_i (biu_line)
  );

  dcache_memory memory_inst (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .lookup_i (lookup), .idx_i (idx), .tag_i (tag), .offs_i (offs),
    .fill_i (fill), .fill_line_i (fill_line),
    .update_i (update), .update_d_i (update_d),
    .invalidate_i (invalidate),
    .hit_o (hit), .line_o (cache_line)
  );

  dcache_biu biu_inst (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .biucmd_i (biucmd), .adr_i (biu_adr), .d_i (biu_d),
    .busy_o (biu_busy), .done_o (biu_done), .err_o (biu_err),
    .q_o (biu_q), .line_o (biu_line),
    .biu_req_o (biu_req_o), .biu_rsp_i (biu_rsp_i)
  );

endmodule

//--- verification/dcache_sva.sv
// Data cache handshake assertions
// Bound into the top level; CPU ack/err pulses and bus request hold
module dcache_sva import dcache_pkg::*, biu_pkg::*; (
  input logic     clk_i,
  input logic     rst_ni,
  input mem_rsp_t mem_rsp_o,
  input logic     cache_flush_rdy_o,
  input biu_req_t biu_req_o,
  input biu_rsp_t biu_rsp_i
);

  // CPU ack is a single cycle
  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rsp_o.ack |=> !mem_rsp_o.ack)
    else $error("CPU ack held for more than one cycle");

  err_with_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rsp_o.err |-> mem_rsp_o.ack)  // err only valid with ack
    else $error("CPU err raised without ack");

  flush_rdy_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cache_flush_rdy_o |=> !cache_flush_rdy_o)
    else $error("Flush ready held for more than one cycle");

  // Bus request waits for its ack
  stb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_req_o.stb && !biu_rsp_i.ack |=> biu_req_o.stb)
    else $error("Bus stb dropped before ack");

  adr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_req_o.stb && !biu_rsp_i.ack |=> $stable(biu_req_o.adr) && $stable(biu_req_o.we))
    else $error("Bus adr or we changed before ack");

endmodule

bind dcache_top dcache_sva sva_inst (
  .clk_i (clk_i), .rst_ni (rst_ni),
  .mem_rsp_o (mem_rsp_o), .cache_flush_rdy_o (cache_flush_rdy_o),
  .biu_req_o (biu_req_o), .biu_rsp_i (biu_rsp_i)
);

//--- verification/dcache_tb.sv
// Data cache testbench
// Table-driven CPU requests against a bus memory model with random wait
// states and a one-shot error, checking data, error flags and bus counts
`include "dcache_consts.svh"

module dcache_tb import dcache_pkg::*, biu_pkg::*;;

  typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_FLUSH} op_t;

  typedef struct {
    op_t   op;
    addr_t adr;
    word_t d;
    bit    exp_err;
    int    exp_bursts;    // DC when replacement makes it unknown
    int    exp_singles;
  } row_t;

  localparam int    DC       = -1;
  localparam int    WAIT_MAX = 200;             // Cycles allowed per access
  localparam addr_t ERR_ADR  = 32'h0000_0248;   // Third beat of line 0x240

  logic     clk_i;
  logic     rst_ni;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  logic     cache_flush;
  logic     cache_flush_rdy;
  biu_req_t biu_req;
  biu_rsp_t biu_rsp;

  word_t bus_mem [4096];   // Bus side memory, word addressed
  row_t  rows [$];
  int    bursts;           // INCR4 bursts seen on the bus
  int    singles;          // SINGLE accesses seen on the bus
  int    errors;
  bit    table_ready;
  bit    err_armed;        // Error fires once, then clears
  bit    bus_active;
  bit    beat_wait;
  int    wait_cnt;
  int    beat_cnt;

  dcache_top DUT (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .mem_req_i (mem_req), .mem_rsp_o (mem_rsp),
    .cache_flush_i (cache_flush), .cache_flush_rdy_o (cache_flush_rdy),
    .biu_req_o (biu_req), .biu_rsp_i (biu_rsp)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  function automatic logic [11:0] mem_index(addr_t adr);
    return adr[13:2];
  endfunction

  //--------------------------------------------------------------------
  // Bus memory model
  //--------------------------------------------------------------------
  always @(negedge clk_i) begin
    biu_rsp = '0;                              // ack lasts one cycle
    if (rst_ni && biu_req.stb) begin
      if (!bus_active) begin                   // Start of a new access
        bus_active = 1'b1;
        beat_cnt   = 0;
        if (biu_req.btype == INCR4) begin
          bursts++;
        end else begin
          singles++;
        end
      end
      if (!beat_wait) begin
        beat_wait = 1'b1;
        wait_cnt  = int'($urandom % 4);         // 0 to 3 wait states
      end
      if (wait_cnt == 0) begin
        beat_wait   = 1'b0;
        beat_cnt++;
        biu_rsp.ack = 1'b1;
        biu_rsp.err = err_armed && (biu_req.adr == ERR_ADR);
        if (biu_rsp.err) begin
          err_armed = 1'b0;
        end else if (biu_req.we) begin
          bus_mem[mem_index(biu_req.adr)] = biu_req.d;
        end else begin
          biu_rsp.q = bus_mem[mem_index(biu_req.adr)];
        end
        if (biu_req.btype == SINGLE || biu_rsp.err || beat_cnt == `DCACHE_BURST) begin
          bus_active = 1'b0;
        end
      end else begin
        wait_cnt--;
      end
    end
  end

  //--------------------------------------------------------------------
  // Stimulus table
  //--------------------------------------------------------------------
  task automatic add_row(op_t op, addr_t adr, word_t d, bit exp_err, int nb, int ns);
    row_t r;
    r = '{op, adr, d, exp_err, nb, ns};
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row(OP_READ,  32'h0000_0104, '0,            0, 1,  0);  // Miss, fill
    add_row(OP_READ,  32'h0000_010C, '0,            0, 0,  0);  // Same line hits
    add_row(OP_WRITE, 32'h0000_0108, 32'hA5A5_1234, 0, 0,  1);  // Write hit
    add_row(OP_READ,  32'h0000_0108, '0,            0, 0,  0);  // Updated word
    add_row(OP_WRITE, 32'h0000_0314, 32'h0BAD_F00D, 0, 0,  1);  // No allocate
    add_row(OP_READ,  32'h0000_0314, '0,            0, 1,  0);
    add_row(OP_READ,  32'h8000_0040, '0,            0, 0,  1);  // Uncached
    add_row(OP_READ,  32'h8000_0040, '0,            0, 0,  1);  // Still uncached
    add_row(OP_WRITE, 32'h8000_0044, 32'h5EED_0044, 0, 0,  1);
    add_row(OP_READ,  32'h8000_0044, '0,            0, 0,  1);
    add_row(OP_FLUSH, '0,            '0,            0, 0,  0);
    add_row(OP_READ,  32'h0000_0104, '0,            0, 1,  0);  // Refill after flush
    add_row(OP_READ,  ERR_ADR,       '0,            1, 1,  0);  // Fill error
    add_row(OP_READ,  ERR_ADR,       '0,            0, 1,  0);  // Retry refills
    add_row(OP_READ,  32'h0000_0054, '0,            0, DC, 0);  // Three lines, set 5
    add_row(OP_READ,  32'h0000_0158, '0,            0, DC, 0);
    add_row(OP_READ,  32'h0000_025C, '0,            0, DC, 0);
    add_row(OP_READ,  32'h0000_0054, '0,            0, DC, 0);
  endtask

  task automatic report_mismatch(string msg);
    $display("mismatch at %0t: %s", $time, msg);
    errors++;
  endtask

  // Called on a falling edge; holds req until ack
  task automatic cpu_access(input logic we, input addr_t adr, input word_t d,
                            output logic err, output word_t q, output bit done);
    int n;
    n    = 0;
    done = 1'b0;
    err  = 1'b0;
    q    = '0;
    mem_req.req = 1'b1;
    mem_req.adr = adr;
    mem_req.we  = we;
    mem_req.d   = d;
    while (!done && n < WAIT_MAX) begin
      @(negedge clk_i);
      n++;
      if (mem_rsp.ack) begin
        done = 1'b1;
        err  = mem_rsp.err;
        q    = mem_rsp.q;
      end
    end
    mem_req = '0;                              // Drop req after ack
  endtask

  task automatic flush_cache(output bit done);
    int n;
    n    = 0;
    done = 1'b0;
    cache_flush = 1'b1;                        // One cycle pulse
    @(negedge clk_i);
    cache_flush = 1'b0;
    while (!done && n < WAIT_MAX) begin
      @(negedge clk_i);
      n++;
      done = cache_flush_rdy;
    end
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------
  initial begin : stimulus
    row_t  r;
    bit    done;
    logic  got_err;
    word_t got_q;
    word_t exp_q;
    int    b0;
    int    s0;
    int    row_errors;

    void'($urandom(62));
    mem_req     = '0;
    cache_flush = 1'b0;
    biu_rsp     = '0;
    rst_ni      = 1'b0;
    bursts      = 0;
    singles     = 0;
    errors      = 0;
    err_armed   = 1'b1;
    bus_active  = 1'b0;
    beat_wait   = 1'b0;
    wait_cnt    = 0;
    beat_cnt    = 0;
    for (int i = 0; i < 4096; i++) begin
      bus_mem[i] = $urandom;
    end
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    foreach (rows[i]) begin
      r          = rows[i];
      row_errors = errors;
      @(negedge clk_i);
      b0 = bursts;
      s0 = singles;
      if (r.op == OP_FLUSH) begin
        flush_cache(done);
      end else begin
        cpu_access(r.op == OP_WRITE, r.adr, r.d, got_err, got_q, done);
      end
      exp_q = bus_mem[mem_index(r.adr)];       // Model word after the access
      if (!done) begin
        $display("row %0d: no response from the cache within %0d cycles", i, WAIT_MAX);
        errors++;
      end else if (r.op != OP_FLUSH) begin
        if (got_err !== r.exp_err) begin
          report_mismatch($sformatf("row %0d err %b expected %b", i, got_err, r.exp_err));
        end
        if (r.op == OP_READ && !r.exp_err && got_q !== exp_q) begin
          report_mismatch($sformatf("row %0d q %h expected %h", i, got_q, exp_q));
        end
        if (r.op == OP_WRITE && exp_q !== r.d) begin
          report_mismatch($sformatf("row %0d bus word %h expected %h", i, exp_q, r.d));
        end
      end
      if (r.exp_bursts != DC && bursts - b0 != r.exp_bursts) begin
        report_mismatch($sformatf("row %0d bursts %0d expected %0d",
                                  i, bursts - b0, r.exp_bursts));
      end
      if (r.exp_singles != DC && singles - s0 != r.exp_singles) begin
        report_mismatch($sformatf("row %0d singles %0d expected %0d",
                                  i, singles - s0, r.exp_singles));
      end
      $display("row %0d %s adr %h: %s", i, r.op.name(), r.adr,
               (errors == row_errors) ? "ok" : "FAILED");
    end

    $display("rows %0d, bursts %0d, singles %0d, errors %0d",
             rows.size(), bursts, singles, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Budget of 300 cycles per table row
  initial begin : watchdog
    wait (table_ready);
    repeat (rows.size() * 300) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, run stopped", rows.size() * 300);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- all.f
+incdir+common
common/dcache_pkg.sv
common/biu_pkg.sv
dcache/dcache_memory.sv
dcache/dcache_biu.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
verification/dcache_sva.sv
verification/dcache_tb.sv

//--- Makefile
VERILATOR  ?= verilator
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only -Wall --timing
TOP        := dcache_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
PASS_MSG   := Done: no errors
SOURCES    := $(wildcard common/* dcache/* verification/*)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
